//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

        localparam int DataWidth   = 8;
        localparam int InstrWidth  = 16;
        localparam int AddrWidth   = 8;
        localparam int OpcodeWidth = 6;
        localparam int AluOpWidth  = 4;
        localparam int StepCount   = 4;

        localparam logic [OpcodeWidth-1:0] OpBra = 6'h00;
        localparam logic [OpcodeWidth-1:0] OpBne = 6'h01;
        localparam logic [OpcodeWidth-1:0] OpInc = 6'h05;
        localparam logic [OpcodeWidth-1:0] OpDec = 6'h06;
        localparam logic [OpcodeWidth-1:0] OpLsl = 6'h07;
        localparam logic [OpcodeWidth-1:0] OpLsr = 6'h08;
        localparam logic [OpcodeWidth-1:0] OpAnd = 6'h0C;
        localparam logic [OpcodeWidth-1:0] OpOr  = 6'h0D;
        localparam logic [OpcodeWidth-1:0] OpNot = 6'h0E;
        localparam logic [OpcodeWidth-1:0] OpXor = 6'h0F;
        localparam logic [OpcodeWidth-1:0] OpLd  = 6'h12;
        localparam logic [OpcodeWidth-1:0] OpSt  = 6'h13;
        localparam logic [OpcodeWidth-1:0] OpLdi = 6'h14;
        localparam logic [OpcodeWidth-1:0] OpAdd = 6'h15;
        localparam logic [OpcodeWidth-1:0] OpSub = 6'h17;
        localparam logic [OpcodeWidth-1:0] OpMov = 6'h18;

        localparam logic [AluOpWidth-1:0] AluMov = 4'd0;
        localparam logic [AluOpWidth-1:0] AluInc = 4'd1;
        localparam logic [AluOpWidth-1:0] AluDec = 4'd2;
        localparam logic [AluOpWidth-1:0] AluAdd = 4'd3;
        localparam logic [AluOpWidth-1:0] AluSub = 4'd4;
        localparam logic [AluOpWidth-1:0] AluAnd = 4'd5;
        localparam logic [AluOpWidth-1:0] AluOr  = 4'd6;
        localparam logic [AluOpWidth-1:0] AluXor = 4'd7;
        localparam logic [AluOpWidth-1:0] AluNot = 4'd8;
        localparam logic [AluOpWidth-1:0] AluLsl = 4'd9;
        localparam logic [AluOpWidth-1:0] AluLsr = 4'd10;

        localparam logic [1:0] SrcAlu = 2'd0;
        localparam logic [1:0] SrcMem = 2'd1;
        localparam logic [1:0] SrcImm = 2'd2;

        typedef struct packed {
                logic [OpcodeWidth-1:0] opcode;
                logic                   setFlags;
                logic [2:0]             dst;
                logic [2:0]             src1;
                logic [2:0]             src2;
        } regFormT;

        typedef struct packed {
                logic [OpcodeWidth-1:0] opcode;
                logic [1:0]             rsel;
                logic [AddrWidth-1:0]   addr;     // Address or immediate.
        } addrFormT;

        typedef union packed {
                regFormT  regForm;
                addrFormT addrForm;
        } instrT;

endpackage

`default_nettype wire

//--- ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

        logic                          regWe;
        logic [1:0]                    regDst;
        logic [1:0]                    regSrcA;
        logic [1:0]                    regSrcB;
        logic [1:0]                    regSource;
        logic [cpuPkg::AluOpWidth-1:0] aluOp;
        logic                          setFlags;
        logic                          zero;

        modport control (output regWe, regDst, regSrcA, regSrcB, regSource, aluOp, setFlags,
                         input zero);
        modport regs (input regWe, regDst, regSrcA, regSrcB, regSource);
        modport alu (input aluOp, setFlags, output zero);

endinterface

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
        parameter logic [cpuPkg::AddrWidth-1:0] ResetPc = '0
) (
        input  wire logic                         T,
        input  wire logic                         rstN,
        input  wire logic [cpuPkg::DataWidth-1:0] memRdata,
        input  wire logic [cpuPkg::DataWidth-1:0] regA,
        output      logic [cpuPkg::AddrWidth-1:0] memAddr,
        output      logic [cpuPkg::DataWidth-1:0] memWdata,
        output      logic                         memWe,
        output      logic [cpuPkg::DataWidth-1:0] imm,
        ctrlIf.control                            ctrl
);

        logic [cpuPkg::StepCount-1:0]   step;
        logic [cpuPkg::StepCount-1:0]   stepNext;
        logic [cpuPkg::AddrWidth-1:0]   pc;
        cpuPkg::instrT                  ir;
        logic [cpuPkg::OpcodeWidth-1:0] opcode;
        logic [cpuPkg::AluOpWidth-1:0]  aluOp;
        logic                           isAlu;
        logic                           isLdi;
        logic                           isLd;
        logic                           isSt;
        logic                           isBra;
        logic                           isBne;
        logic                           isMem;
        logic                           takeBranch;

        assign opcode = ir.regForm.opcode;
        assign isLdi  = (opcode == cpuPkg::OpLdi);
        assign isLd   = (opcode == cpuPkg::OpLd);
        assign isSt   = (opcode == cpuPkg::OpSt);
        assign isBra  = (opcode == cpuPkg::OpBra);
        assign isBne  = (opcode == cpuPkg::OpBne);
        assign isMem  = isLd | isSt;

        // Flags still hold the previous instruction's result here.
        assign takeBranch = isBra | (isBne & ~ctrl.zero);

        always_comb begin
                isAlu = 1'b1;
                aluOp = cpuPkg::AluMov;
                case (opcode)
                        cpuPkg::OpMov: aluOp = cpuPkg::AluMov;
                        cpuPkg::OpInc: aluOp = cpuPkg::AluInc;
                        cpuPkg::OpDec: aluOp = cpuPkg::AluDec;
                        cpuPkg::OpAdd: aluOp = cpuPkg::AluAdd;
                        cpuPkg::OpSub: aluOp = cpuPkg::AluSub;
                        cpuPkg::OpAnd: aluOp = cpuPkg::AluAnd;
                        cpuPkg::OpOr:  aluOp = cpuPkg::AluOr;
                        cpuPkg::OpXor: aluOp = cpuPkg::AluXor;
                        cpuPkg::OpNot: aluOp = cpuPkg::AluNot;
                        cpuPkg::OpLsl: aluOp = cpuPkg::AluLsl;
                        cpuPkg::OpLsr: aluOp = cpuPkg::AluLsr;
                        default:       isAlu = 1'b0;
                endcase
        end

        // Only LD and ST run on into T3.
        always_comb begin
                stepNext = {step[cpuPkg::StepCount-2:0], 1'b0};
                if (step[3] || (step[2] && !isMem)) begin
                        stepNext = {{(cpuPkg::StepCount-1){1'b0}}, 1'b1};
                end
        end

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        step <= {{(cpuPkg::StepCount-1){1'b0}}, 1'b1};
                        pc   <= ResetPc;
                        ir   <= '0;
                end else begin
                        step <= stepNext;
                        if (step[0]) begin
                                ir[7:0] <= memRdata;       // Low byte first.
                                pc      <= pc + 1'b1;
                        end
                        if (step[1]) begin
                                ir[15:8] <= memRdata;
                                pc       <= pc + 1'b1;
                        end
                        if (step[2] && takeBranch) begin
                                pc <= ir.addrForm.addr;
                        end
                end
        end

        assign memAddr  = step[3] ? ir.addrForm.addr : pc;
        assign memWdata = regA;
        assign memWe    = step[3] & isSt;
        assign imm      = ir.addrForm.addr;

        // Register view for ALU opcodes, address view otherwise.
        assign ctrl.regDst   = isAlu ? ir.regForm.dst[1:0] : ir.addrForm.rsel;
        assign ctrl.regSrcA  = isAlu ? ir.regForm.src1[1:0] : ir.addrForm.rsel;
        assign ctrl.regSrcB  = ir.regForm.src2[1:0];
        assign ctrl.aluOp    = aluOp;
        assign ctrl.setFlags = step[2] & isAlu & ir.regForm.setFlags;

        always_comb begin
                ctrl.regSource = cpuPkg::SrcAlu;
                if (isLd) begin
                        ctrl.regSource = cpuPkg::SrcMem;
                end else if (isLdi) begin
                        ctrl.regSource = cpuPkg::SrcImm;
                end
        end

        assign ctrl.regWe = (step[2] & (isAlu | isLdi)) | (step[3] & isLd);

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
        input  wire logic                         T,
        input  wire logic                         rstN,
        input  wire logic [cpuPkg::DataWidth-1:0] aluResult,
        input  wire logic [cpuPkg::DataWidth-1:0] memRdata,
        input  wire logic [cpuPkg::DataWidth-1:0] imm,
        output      logic [cpuPkg::DataWidth-1:0] regA,
        output      logic [cpuPkg::DataWidth-1:0] regB,
        ctrlIf.regs                               ctrl
);

        logic [cpuPkg::DataWidth-1:0] regs [4];
        logic [cpuPkg::DataWidth-1:0] writeData;

        always_comb begin
                case (ctrl.regSource)
                        cpuPkg::SrcMem: writeData = memRdata;
                        cpuPkg::SrcImm: writeData = imm;
                        default:        writeData = aluResult;
                endcase
        end

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < 4; i++) begin
                                regs[i] <= '0;
                        end
                end else if (ctrl.regWe) begin
                        regs[ctrl.regDst] <= writeData;
                end
        end

        assign regA = regs[ctrl.regSrcA];     // Also the store data.
        assign regB = regs[ctrl.regSrcB];

endmodule

`default_nettype wire

//--- arithmeticLogicUnit.sv
`timescale 1ns/1ps
`default_nettype none

module arithmeticLogicUnit (
        input  wire logic                         T,
        input  wire logic                         rstN,
        input  wire logic [cpuPkg::DataWidth-1:0] regA,
        input  wire logic [cpuPkg::DataWidth-1:0] regB,
        output      logic [cpuPkg::DataWidth-1:0] aluResult,
        ctrlIf.alu                                ctrl
);

        // Top bit carries C out of every operation.
        logic [cpuPkg::DataWidth:0] wide;
        logic                       zFlag;
        logic                       nFlag;
        logic                       cFlag;

        always_comb begin
                case (ctrl.aluOp)
                        cpuPkg::AluInc: wide = {1'b0, regA} + 1'b1;
                        cpuPkg::AluDec: wide = {1'b0, regA} + {1'b0, {cpuPkg::DataWidth{1'b1}}};
                        cpuPkg::AluAdd: wide = {1'b0, regA} + {1'b0, regB};
                        cpuPkg::AluSub: wide = {1'b0, regA} + {1'b0, ~regB} + 1'b1;
                        cpuPkg::AluAnd: wide = {1'b0, regA & regB};
                        cpuPkg::AluOr:  wide = {1'b0, regA | regB};
                        cpuPkg::AluXor: wide = {1'b0, regA ^ regB};
                        cpuPkg::AluNot: wide = {1'b0, ~regA};
                        cpuPkg::AluLsl: wide = {regA, 1'b0};
                        cpuPkg::AluLsr: wide = {regA[0], 1'b0, regA[cpuPkg::DataWidth-1:1]};
                        default:        wide = {1'b0, regA};   // MOV.
                endcase
        end

        assign aluResult = wide[cpuPkg::DataWidth-1:0];

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        zFlag <= 1'b0;
                        nFlag <= 1'b0;
                        cFlag <= 1'b0;
                end else if (ctrl.setFlags) begin
                        zFlag <= (aluResult == '0);
                        nFlag <= aluResult[cpuPkg::DataWidth-1];
                        cFlag <= wide[cpuPkg::DataWidth];
                end
        end

        assign ctrl.zero = zFlag;

endmodule

`default_nettype wire

//--- cpuSystem.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystem #(
        parameter logic [cpuPkg::AddrWidth-1:0] ResetPc = '0
) (
        input  wire logic                         T,
        input  wire logic                         rstN,
        input  wire logic [cpuPkg::DataWidth-1:0] memRdata,
        output      logic [cpuPkg::AddrWidth-1:0] memAddr,
        output      logic [cpuPkg::DataWidth-1:0] memWdata,
        output      logic                         memWe
);

        logic [cpuPkg::DataWidth-1:0] regA;
        logic [cpuPkg::DataWidth-1:0] regB;
        logic [cpuPkg::DataWidth-1:0] aluResult;
        logic [cpuPkg::DataWidth-1:0] imm;

        ctrlIf ctrl ();

        controlUnit #(
                .ResetPc (ResetPc)
        ) i_control (
                .T        (T),
                .rstN     (rstN),
                .memRdata (memRdata),
                .regA     (regA),
                .memAddr  (memAddr),
                .memWdata (memWdata),
                .memWe    (memWe),
                .imm      (imm),
                .ctrl     (ctrl.control)
        );

        registerFile i_regs (
                .T         (T),
                .rstN      (rstN),
                .aluResult (aluResult),
                .memRdata  (memRdata),
                .imm       (imm),
                .regA      (regA),
                .regB      (regB),
                .ctrl      (ctrl.regs)
        );

        arithmeticLogicUnit i_alu (
                .T         (T),
                .rstN      (rstN),
                .regA      (regA),
                .regB      (regB),
                .aluResult (aluResult),
                .ctrl      (ctrl.alu)
        );

endmodule

`default_nettype wire

//--- cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker #(
        parameter logic [cpuPkg::AddrWidth-1:0] ResetPc = '0
) (
        input  wire logic                         T,
        input  wire logic                         rstN,
        input  wire logic [cpuPkg::AddrWidth-1:0] memAddr,
        input  wire logic [cpuPkg::DataWidth-1:0] memWdata,
        input  wire logic                         memWe,
        input  wire logic [cpuPkg::DataWidth-1:0] mem [256],
        input  wire logic                         endRun,
        output      int                           mismatches,
        output      int                           unexpected,
        output      int                           missing,
        output      int                           maxCycles
);

        logic [cpuPkg::AddrWidth-1:0] expAddr [$];
        logic [cpuPkg::DataWidth-1:0] expData [$];
        logic                         fetchSeen = 1'b0;

        // Each test stores into its own block of addresses.
        function automatic string testName(input logic [7:0] addr);
                case (addr[7:4])
                        4'hF:    return "resetFetch";
                        4'hA:    return "aluTwoSource";
                        4'hB:    return "aluOneSource";
                        4'hC:    return "memRoundTrip";
                        4'hD:    return "branchLoop";
                        default: return "unknown";
                endcase
        endfunction

        // Runs the image up to the jump to itself and queues every store.
        function automatic int runModel();
                logic [7:0]  img [256];
                logic [7:0]  r [4];
                logic [7:0]  pc;
                logic [7:0]  a;
                logic [7:0]  res;
                logic [15:0] w;
                logic        z;
                logic        isAlu;
                logic        halted;
                int          count;
                img    = mem;
                r      = '{default: '0};
                pc     = ResetPc;
                z      = 1'b0;
                halted = 1'b0;
                count  = 0;
                while (!halted && count < 2000) begin
                        w  = {img[pc + 8'd1], img[pc]};      // Low byte first.
                        pc = pc + 8'd2;
                        count++;
                        a     = r[w[4:3]];
                        isAlu = 1'b1;
                        case (w[15:10])
                                cpuPkg::OpMov: res = a;
                                cpuPkg::OpInc: res = a + 8'd1;
                                cpuPkg::OpDec: res = a - 8'd1;
                                cpuPkg::OpAdd: res = a + r[w[1:0]];
                                cpuPkg::OpSub: res = a - r[w[1:0]];
                                cpuPkg::OpAnd: res = a & r[w[1:0]];
                                cpuPkg::OpOr:  res = a | r[w[1:0]];
                                cpuPkg::OpXor: res = a ^ r[w[1:0]];
                                cpuPkg::OpNot: res = ~a;
                                cpuPkg::OpLsl: res = a << 1;
                                cpuPkg::OpLsr: res = a >> 1;
                                default: begin
                                        res   = a;
                                        isAlu = 1'b0;
                                end
                        endcase
                        if (isAlu) begin
                                r[w[7:6]] = res;
                                if (w[9]) begin
                                        z = (res == 8'd0);
                                end
                        end
                        case (w[15:10])
                                cpuPkg::OpLdi: r[w[9:8]] = w[7:0];
                                cpuPkg::OpLd:  r[w[9:8]] = img[w[7:0]];
                                cpuPkg::OpSt: begin
                                        img[w[7:0]] = r[w[9:8]];
                                        expAddr.push_back(w[7:0]);
                                        expData.push_back(r[w[9:8]]);
                                end
                                cpuPkg::OpBra: begin
                                        halted = (w[7:0] == pc - 8'd2);   // Jump to itself.
                                        pc     = w[7:0];
                                end
                                cpuPkg::OpBne: if (!z) pc = w[7:0];
                                default: ;
                        endcase
                end
                return count;
        endfunction

        always @(posedge rstN) begin
                expAddr.delete();
                expData.delete();
                maxCycles = runModel() * 4 + 50;
        end

        always @(posedge T) begin
                if (rstN && !fetchSeen) begin
                        fetchSeen = 1'b1;
                        if (memAddr !== ResetPc) begin
                                $display("CHECK FAILED test=resetFetch expected=%h actual=%h",
                                         ResetPc, memAddr);
                                mismatches++;
                        end
                end
                if (rstN && memWe) begin
                        if (expAddr.size() == 0) begin
                                $display("Store of %h to address %h was not expected by the model.",
                                         memWdata, memAddr);
                                unexpected++;
                        end else begin
                                if (memAddr !== expAddr[0]) begin
                                        $display("CHECK FAILED test=%s address expected=%h actual=%h",
                                                 testName(expAddr[0]), expAddr[0], memAddr);
                                        mismatches++;
                                end
                                if (memWdata !== expData[0]) begin
                                        $display("CHECK FAILED test=%s data expected=%h actual=%h",
                                                 testName(expAddr[0]), expData[0], memWdata);
                                        mismatches++;
                                end
                                void'(expAddr.pop_front());
                                void'(expData.pop_front());
                        end
                end
        end

        always @(posedge endRun) begin
                if (expAddr.size() != 0) begin
                        $display("%0d stores expected by the model never happened, first at address %h.",
                                 expAddr.size(), expAddr[0]);
                        missing = expAddr.size();
                end
        end

endmodule

`default_nettype wire

//--- cpuSystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystem_tb;

        localparam logic [cpuPkg::AddrWidth-1:0] ResetPc    = 8'h00;
        localparam int                           HalfPeriod = 20;

        logic                         T;
        logic                         rstN;
        logic [cpuPkg::DataWidth-1:0] memRdata;
        logic [cpuPkg::AddrWidth-1:0] memAddr;
        logic [cpuPkg::DataWidth-1:0] memWdata;
        logic                         memWe;
        logic [cpuPkg::DataWidth-1:0] mem [256];
        logic                         endRun;
        int                           mismatches;
        int                           unexpected;
        int                           missing;
        int                           maxCycles;
        int                           timeouts;
        logic [31:0]                  lfsr;
        logic [cpuPkg::AddrWidth-1:0] progPc;
        logic [cpuPkg::AddrWidth-1:0] haltPc;

        cpuSystem #(.ResetPc(ResetPc)) i_dut (.*);
        cpuChecker #(.ResetPc(ResetPc)) i_checker (.*);

        always #HalfPeriod T = ~T;

        assign memRdata = mem[memAddr];

        always @(posedge T) begin
                if (memWe) begin
                        mem[memAddr] <= memWdata;
                end
        end

        // Taps 32, 22, 2 and 1.
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [7:0] randomBits(input int n);
                logic [7:0] value;
                value = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr  = lfsrNext(lfsr);
                        value = {value[6:0], lfsr[0]};
                end
                return value;
        endfunction

        function automatic logic [15:0] regInstr(input logic [5:0] op, input logic setFlags,
                                                 input logic [1:0] dst, input logic [1:0] src1,
                                                 input logic [1:0] src2);
                return {op, setFlags, 1'b0, dst, 1'b0, src1, 1'b0, src2};
        endfunction

        function automatic logic [15:0] addrInstr(input logic [5:0] op, input logic [1:0] rsel,
                                                  input logic [7:0] addr);
                return {op, rsel, addr};
        endfunction

        task automatic emit(input logic [15:0] word);
                mem[progPc]        = word[7:0];
                mem[progPc + 8'd1] = word[15:8];
                progPc             = progPc + 8'd2;
        endtask

        task automatic loadProgram();
                logic [5:0] twoOps [5];
                logic [5:0] oneOps [6];
                logic [7:0] loopPc;
                logic [7:0] count;
                twoOps = '{cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd, cpuPkg::OpOr,
                           cpuPkg::OpXor};
                oneOps = '{cpuPkg::OpMov, cpuPkg::OpInc, cpuPkg::OpDec, cpuPkg::OpNot,
                           cpuPkg::OpLsl, cpuPkg::OpLsr};
                for (int i = 0; i < 256; i++) begin
                        mem[i] = 8'(i) ^ 8'h5A;
                end
                for (int i = 0; i < 3; i++) begin
                        mem[8'h90 + i] = randomBits(8);     // Round trip operands.
                end
                progPc = ResetPc;
                emit(addrInstr(cpuPkg::OpLdi, 2'd0, randomBits(8)));
                emit(addrInstr(cpuPkg::OpSt, 2'd0, 8'hF0));
                foreach (twoOps[i]) begin
                        emit(addrInstr(cpuPkg::OpLdi, 2'd1, randomBits(8)));
                        emit(addrInstr(cpuPkg::OpLdi, 2'd2, randomBits(8)));
                        emit(regInstr(twoOps[i], 1'b0, 2'd3, 2'd1, 2'd2));
                        emit(addrInstr(cpuPkg::OpSt, 2'd3, 8'hA0 + 8'(i)));
                end
                foreach (oneOps[i]) begin
                        emit(addrInstr(cpuPkg::OpLdi, 2'd1, randomBits(8)));
                        emit(regInstr(oneOps[i], 1'b1, 2'd2, 2'd1, 2'd0));
                        emit(addrInstr(cpuPkg::OpSt, 2'd2, 8'hB0 + 8'(i)));
                end
                emit(addrInstr(cpuPkg::OpLd, 2'd0, 8'h90));
                emit(addrInstr(cpuPkg::OpLd, 2'd1, 8'h91));
                emit(regInstr(cpuPkg::OpAdd, 1'b0, 2'd2, 2'd0, 2'd1));
                emit(addrInstr(cpuPkg::OpLd, 2'd1, 8'h92));
                emit(regInstr(cpuPkg::OpAdd, 1'b0, 2'd2, 2'd2, 2'd1));
                emit(addrInstr(cpuPkg::OpSt, 2'd2, 8'hC0));
                count = randomBits(3) + 8'd2;   // At least two passes.
                emit(addrInstr(cpuPkg::OpLdi, 2'd0, count));
                emit(addrInstr(cpuPkg::OpLdi, 2'd3, 8'd1));   // First DEC of r3 hits zero.
                loopPc = progPc;
                emit(addrInstr(cpuPkg::OpSt, 2'd0, 8'hD0));
                emit(regInstr(cpuPkg::OpDec, 1'b1, 2'd0, 2'd0, 2'd0));
                emit(regInstr(cpuPkg::OpDec, 1'b0, 2'd3, 2'd3, 2'd0));
                emit(addrInstr(cpuPkg::OpBne, 2'd0, loopPc));
                emit(addrInstr(cpuPkg::OpBra, 2'd0, progPc + 8'd4));
                emit(addrInstr(cpuPkg::OpSt, 2'd0, 8'hE0));   // Skipped.
                haltPc = progPc;
                emit(addrInstr(cpuPkg::OpBra, 2'd0, haltPc));
        endtask

        initial begin
                T        = 1'b0;
                rstN     = 1'b0;
                endRun   = 1'b0;
                timeouts = 0;
                lfsr     = 32'h6266;
                loadProgram();
                repeat (4) @(negedge T);
                rstN = 1'b1;
                @(posedge T);
                fork
                        begin
                                @(negedge T);
                                while (memAddr !== haltPc) begin
                                        @(negedge T);
                                end
                        end
                        begin
                                #(maxCycles * 2 * HalfPeriod);
                                $display("Run timed out after %0d cycles before the halt loop.",
                                         maxCycles);
                                timeouts++;
                        end
                join_any
                disable fork;
                @(negedge T);
                endRun = 1'b1;
                @(posedge T);
                $display("Errors: %0d mismatches, %0d unexpected, %0d missing, %0d timeouts.",
                         mismatches, unexpected, missing, timeouts);
                if (mismatches + unexpected + missing + timeouts == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- cpuSystem.f
cpuPkg.sv
ctrlIf.sv
controlUnit.sv
registerFile.sv
arithmeticLogicUnit.sv
cpuSystem.sv
cpuChecker.sv
cpuSystem_tb.sv

//--- Bender.yml
package:
  name: cpu_system

sources:
  - files:
      - cpuPkg.sv
      - ctrlIf.sv
      - controlUnit.sv
      - registerFile.sv
      - arithmeticLogicUnit.sv
      - cpuSystem.sv
  - target: test
    files:
      - cpuChecker.sv
      - cpuSystem_tb.sv
